// File: include/rx_buf_config.svh
// sizing macros for the receive sample buffer: channel count, frame words, buffer depth, nsamps

`ifndef RX_BUF_CONFIG_SVH
`define RX_BUF_CONFIG_SVH

// receiver channels carried in every frame
`define RX_CHANS 4

// words per channel per frame (I, Q, iq3)
`define RX_WORDS_PER_CHAN 3

// sample buffer address width, 256 words
// kept small so the buffer fills and back-pressure shows up
`define RX_BUF_AW 8

`define RX_DEF_NSAMPS 4		// frames per block after reset
`define RX_NSAMPS_W 7		// nsamps register width, legal values 1..127

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the receive buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module rx_buf_tb -f sim.f -o rx_buf_sim

out="$(./obj_dir/rx_buf_sim)"
echo "$out"

if grep -q "Testbench passed" <<< "$out"; then
	exit 0
fi
exit 1

// File: sim.f
+incdir+include
verilog/rx_buf_pkg.sv
verilog/rx_frame_sequencer.sv
verilog/rx_sample_ram.sv
verilog/rx_host_reader.sv
verilog/rx_buf_top.sv
sim/rx_buf_asserts.sv
sim/rx_buf_tb.sv

// File: sim/rx_buf_asserts.sv
// concurrent checks for a valid/ready word port and two conditions that must never meet

`default_nettype none

`include "rx_buf_config.svh"

module rx_buf_asserts
	import rx_buf_pkg::*;
(
	input  wire				clk_i,
	input  wire				rst_i,
	input  wire				valid_i,		// word stream valid
	input  wire				ready_i,		// word stream ready
	input  wire rx_word_t	data_i,
	input  wire				excl_a_i,		// never high together with excl_b_i
	input  wire				excl_b_i
);

	////////////////////////////////////////
	// handshake
	////////////////////////////////////////

	// a stalled word stays offered
	a_valid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		valid_i && !ready_i |=> valid_i)
		else $error("word valid dropped before ready");

	a_data_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		valid_i && !ready_i |=> $stable(data_i))
		else $error("word data changed while stalled");

	// event driven by a neighbour module vs a local state it must respect
	a_excl: assert property (@(posedge clk_i) disable iff (rst_i)
		!(excl_a_i && excl_b_i))
		else $error("exclusive conditions high together");

endmodule

`default_nettype wire

// File: sim/rx_buf_tb.sv
// testbench for the receive sample buffer: clock, reset, lfsr stimulus, word queue model, checks

`default_nettype none

`include "rx_buf_config.svh"

module rx_buf_tb
	import rx_buf_pkg::*;
;

	localparam int FW = `RX_CHANS * `RX_WORDS_PER_CHAN;		// words per frame
	localparam int PLANNED_FRAMES = 140;		// all phases plus block fill-up
	localparam int CYCLE_LIMIT = PLANNED_FRAMES * 16 + 6000;

	logic					cpu_clk;
	logic					reset_bufs_A;
	logic					frame_valid_i;
	logic					frame_ready_o;
	rx_word_t [FW-1:0]		frame_data_i;
	logic [1:0]				ticks_sel_o;
	rx_word_t				ticks_i;
	logic					host_cmd_valid_i;
	logic					host_cmd_ready_o;
	host_cmd_t				host_cmd_i;
	rx_word_t				host_arg_i;
	logic					host_rd_o;
	rx_word_t				host_dout_o;
	logic					srq_o;

	rx_word_t	tick_tab [4];		// entry 3 never selected
	rx_word_t	model_q [$];		// words the host should read, in order
	int			model_blk_count;
	bit			model_srq;
	int			model_frame_cnt;
	int			model_nsamps;
	int			model_blk_ns;		// nsamps latched at block start
	logic [15:0]	lfsr_state;
	bit			frame_acc;
	bit			cmd_acc;
	bit			pend_valid;			// response due next cycle
	rx_word_t	pend_val;
	int			frames_req;
	int			host_mode;			// 0 directed, 1 random, 2 drain
	int			rst_cnt;
	bit			dir_req;
	host_cmd_t	dir_cmd;
	rx_word_t	dir_arg;
	int			err_cnt;
	int			chk_cnt;
	int			cycle_cnt;
	int			stall;

	assign ticks_i = tick_tab[ticks_sel_o];		// combinational tick source

	rx_buf_top u_rx_buf_top (
		.cpu_clk			(cpu_clk),
		.reset_bufs_A		(reset_bufs_A),
		.frame_valid_i		(frame_valid_i),
		.frame_ready_o		(frame_ready_o),
		.frame_data_i		(frame_data_i),
		.ticks_sel_o		(ticks_sel_o),
		.ticks_i			(ticks_i),
		.host_cmd_valid_i	(host_cmd_valid_i),
		.host_cmd_ready_o	(host_cmd_ready_o),
		.host_cmd_i			(host_cmd_i),
		.host_arg_i			(host_arg_i),
		.host_rd_o			(host_rd_o),
		.host_dout_o		(host_dout_o),
		.srq_o				(srq_o)
	);

	// no frame taken while the block length from the reader reads zero
	bind rx_frame_sequencer rx_buf_asserts u_seq_chk (
		.clk_i(cpu_clk), .rst_i(reset_bufs_A), .valid_i(word_valid_o),
		.ready_i(word_ready_i), .data_i(word_data_o),
		.excl_a_i(frame_take), .excl_b_i(nsamps_i == '0)
	);
	// the reader never asks an empty buffer for a word
	bind rx_sample_ram rx_buf_asserts u_ram_chk (
		.clk_i(cpu_clk), .rst_i(reset_bufs_A), .valid_i(wr_valid_i),
		.ready_i(wr_ready_o), .data_i(wr_data_i),
		.excl_a_i(rd_en_i), .excl_b_i(empty_o)
	);

	initial
	begin
		cpu_clk = 1'b0;
		forever #4 cpu_clk = ~cpu_clk;
	end

	////////////////////////////////////////
	// random bits and error reporting
	////////////////////////////////////////

	// fibonacci lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function logic [15:0] rand_bits(input int n);
		logic [15:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);		// one step per bit
			r = {r[14:0], lfsr_state[0]};
		end
		return r;
	endfunction

	task value_error(input string msg, input rx_word_t got, input rx_word_t exp);
		$display("CHECK FAILED t=%0t: %s got %h expected %h", $time, msg, got, exp);
		err_cnt++;
	endtask

	task other_error(input string msg);
		$display("error at t=%0t: %s", $time, msg);
		err_cnt++;
	endtask

	////////////////////////////////////////
	// model, fed from the pre-edge values
	////////////////////////////////////////

	task push_frame();
		if (model_frame_cnt == 0)
			model_blk_ns = model_nsamps;		// block length fixed at first frame
		for (int c = 0; c < `RX_CHANS; c++)
			for (int k = 0; k < `RX_WORDS_PER_CHAN; k++)
				model_q.push_back(frame_data_i[c * `RX_WORDS_PER_CHAN + k]);
		model_frame_cnt++;
		if (model_frame_cnt == model_blk_ns)
		begin
			for (int t = 0; t < 3; t++)
				model_q.push_back(tick_tab[t]);		// ticks in select order
			model_q.push_back(rx_word_t'(model_blk_count));		// count before block
			model_blk_count++;
			model_srq = 1'b1;
			model_frame_cnt = 0;
		end
	endtask

	task monitor();
		if (reset_bufs_A)
		begin
			model_q.delete();
			model_blk_count = 0;
			model_srq = 1'b0;
			model_frame_cnt = 0;
			model_nsamps = `RX_DEF_NSAMPS;
			model_blk_ns = `RX_DEF_NSAMPS;
			pend_valid = 1'b0;
			frame_acc = 1'b0;
			cmd_acc = 1'b0;
			return;
		end
		// response to last cycle's command
		if (host_rd_o && !pend_valid)
			other_error("response strobe without an accepted read command");
		else if (pend_valid && !host_rd_o)
			other_error("no response strobe one cycle after a read command");
		else if (pend_valid)
		begin
			chk_cnt++;
			if (host_dout_o != pend_val)
				value_error("host response", host_dout_o, pend_val);
		end
		pend_valid = 1'b0;
		frame_acc = frame_valid_i && frame_ready_o;
		cmd_acc = host_cmd_valid_i && host_cmd_ready_o;
		if (frame_acc)
			push_frame();
		if (cmd_acc)
		begin
			case (host_cmd_i)
				CMD_GET_SAMP:
				begin
					if (model_q.size() == 0)
						other_error("sample read accepted with nothing expected");
					else
					begin
						pend_val = model_q.pop_front();
						pend_valid = 1'b1;
					end
				end
				CMD_GET_BUF_CTR:
				begin
					pend_val = rx_word_t'(model_blk_count);
					pend_valid = 1'b1;
				end
				CMD_GET_SRQ:
				begin
					pend_val = rx_word_t'(model_srq);
					pend_valid = 1'b1;
					model_srq = 1'b0;		// read clears
				end
				CMD_SET_NSAMPS: model_nsamps = (host_arg_i == '0) ? 1 : int'(host_arg_i);
				default: ;
			endcase
		end
	endtask

	////////////////////////////////////////
	// stimulus, one call per rising edge
	////////////////////////////////////////

	task drive();
		logic [15:0] r;
		if (rst_cnt > 0)
		begin
			reset_bufs_A <= 1'b1;
			rst_cnt--;
			frame_valid_i <= 1'b0;
			host_cmd_valid_i <= 1'b0;
			return;
		end
		reset_bufs_A <= 1'b0;
		// frame slot is free once the last one went through
		if (!frame_valid_i || frame_acc)
		begin
			if (frames_req > 0 && rand_bits(2) != 2'd0)
			begin
				frame_valid_i <= 1'b1;
				for (int w = 0; w < FW; w++)
					frame_data_i[w] <= rx_word_t'(rand_bits(16));
				frames_req--;
			end
			else
				frame_valid_i <= 1'b0;
		end
		if (!host_cmd_valid_i || cmd_acc)		// else hold the stalled command
		begin
			r = rand_bits(3);
			host_cmd_valid_i <= 1'b0;
			host_cmd_i <= CMD_NOP;
			if (dir_req)
			begin
				host_cmd_valid_i <= 1'b1;
				host_cmd_i <= dir_cmd;
				host_arg_i <= dir_arg;
				dir_req = 1'b0;
			end
			else if (host_mode == 1 && r < 16'd5 && model_q.size() > 0)
			begin
				host_cmd_valid_i <= 1'b1;
				host_cmd_i <= CMD_GET_SAMP;
			end
			else if (host_mode == 1 && r == 16'd6)
			begin
				host_cmd_valid_i <= 1'b1;
				host_cmd_i <= CMD_SET_NSAMPS;
				host_arg_i <= rx_word_t'(rand_bits(3) % 16'd7);		// 0..6
			end
			else if (host_mode == 2 && model_q.size() > 0)
			begin
				host_cmd_valid_i <= 1'b1;
				host_cmd_i <= CMD_GET_SAMP;
			end
		end
	endtask

	task cycle();
		@(posedge cpu_clk);
		monitor();
		drive();
		#1;		// let the driven values settle for the caller
	endtask

	task send_cmd(input host_cmd_t cmd, input rx_word_t arg);
		dir_cmd = cmd;
		dir_arg = arg;
		dir_req = 1'b1;
		cycle();
		while (dir_req || host_cmd_valid_i || pend_valid)
			cycle();
	endtask

	// complete the open block, then read everything back
	task finish_and_drain();
		host_mode = 2;
		while (frames_req > 0 || frame_valid_i || model_frame_cnt != 0)
		begin
			if (frames_req == 0 && !frame_valid_i && model_frame_cnt != 0)
				frames_req = model_blk_ns - model_frame_cnt;
			cycle();
		end
		while (model_q.size() > 0 || host_cmd_valid_i || pend_valid)
			cycle();
		host_mode = 0;
	endtask

	// service request pin against the model flag
	task check_srq_pin(input bit exp);
		chk_cnt++;
		if (srq_o !== exp)
			value_error("srq pin", rx_word_t'(srq_o), rx_word_t'(exp));
	endtask

	task quiet_checks();
		send_cmd(CMD_GET_BUF_CTR, '0);
		check_srq_pin(model_srq);		// raised by the blocks just read
		send_cmd(CMD_GET_SRQ, '0);		// set by the blocks just read
		check_srq_pin(1'b0);
		send_cmd(CMD_GET_SRQ, '0);		// cleared now
	endtask

	// watchdog
	initial
	begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT)
		begin
			@(posedge cpu_clk);
			cycle_cnt++;
		end
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Testbench failed");
		$finish;
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial
	begin
		reset_bufs_A = 1'b1;
		frame_valid_i = 1'b0;
		frame_data_i = '0;
		host_cmd_valid_i = 1'b0;
		host_cmd_i = CMD_NOP;
		host_arg_i = '0;
		lfsr_state = 16'd4609;
		err_cnt = 0;
		chk_cnt = 0;
		frames_req = 0;
		host_mode = 0;
		dir_req = 1'b0;
		pend_valid = 1'b0;
		frame_acc = 1'b0;
		cmd_acc = 1'b0;
		rst_cnt = 7;		// first edge already sees reset high
		for (int t = 0; t < 4; t++)
			tick_tab[t] = rx_word_t'(rand_bits(16));
		while (rst_cnt > 0 || reset_bufs_A)
			cycle();
		send_cmd(CMD_GET_SRQ, '0);		// nothing done yet
		send_cmd(CMD_GET_BUF_CTR, '0);

		// random frames, reads and block lengths
		host_mode = 1;
		frames_req = 60;
		while (frames_req > 0)
			cycle();
		finish_and_drain();
		quiet_checks();

		// zero clamps to one frame per block
		send_cmd(CMD_SET_NSAMPS, '0);
		frames_req = 5;
		finish_and_drain();
		quiet_checks();

		// host stops reading until the producer stalls
		send_cmd(CMD_SET_NSAMPS, 16'd3);
		frames_req = 40;
		stall = 0;
		while (stall < 64)
		begin
			cycle();
			if (frame_valid_i && !frame_ready_o)
				stall++;
			else
				stall = 0;
		end
		if (model_q.size() < (1 << `RX_BUF_AW))
			other_error("producer stalled before the buffer was full");
		finish_and_drain();
		quiet_checks();

		// buffer reset in the middle of a block, srq already raised
		frames_req = 6;
		while (!srq_o)
			cycle();
		repeat (8)
			cycle();
		frames_req = 0;
		rst_cnt = 8;
		while (rst_cnt > 0 || reset_bufs_A)
			cycle();
		check_srq_pin(1'b0);
		send_cmd(CMD_GET_SRQ, '0);
		send_cmd(CMD_GET_BUF_CTR, '0);
		frames_req = `RX_DEF_NSAMPS;		// counter word must read 0
		finish_and_drain();
		quiet_checks();

		$display("checks run %0d, errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/rx_buf_pkg.sv
// shared vector typedefs, sequencer state enum and host command enum for the sample buffer

`default_nettype none

`include "rx_buf_config.svh"

package rx_buf_pkg;

	typedef logic [15:0] rx_word_t;					// one sample word
	typedef logic [1:0] rx_chan_t;					// receiver channel index
	typedef logic [`RX_BUF_AW-1:0] rx_addr_t;		// sample buffer address
	typedef logic [`RX_NSAMPS_W-1:0] rx_nsamps_t;	// frames per block
	typedef logic [15:0] rx_ctr_t;					// block counter

	// producer states
	typedef enum logic [1:0] {
		SEQ_IDLE,		// waiting for a frame
		SEQ_CHAN,		// moving channel words
		SEQ_TICKS,		// moving the three tick words
		SEQ_CTR			// moving the block counter word
	} seq_state_t;

	// host command codes
	typedef enum logic [2:0] {
		CMD_NOP         = 3'd0,
		CMD_GET_SAMP    = 3'd1,
		CMD_GET_BUF_CTR = 3'd2,
		CMD_GET_SRQ     = 3'd3,
		CMD_SET_NSAMPS  = 3'd4
	} host_cmd_t;

endpackage

`default_nettype wire

// File: verilog/rx_buf_top.sv
// top level of the receive sample buffer: sequencer, sample memory and host reader

`default_nettype none

`include "rx_buf_config.svh"

module rx_buf_top
	import rx_buf_pkg::*;
(
	input  wire											cpu_clk,
	input  wire											reset_bufs_A,
	// frame input
	input  wire											frame_valid_i,
	output logic										frame_ready_o,
	input  wire rx_word_t [`RX_CHANS*`RX_WORDS_PER_CHAN-1:0]	frame_data_i,
	// tick source
	output logic [1:0]									ticks_sel_o,
	input  wire rx_word_t								ticks_i,
	// host command and response
	input  wire											host_cmd_valid_i,
	output logic										host_cmd_ready_o,
	input  wire host_cmd_t								host_cmd_i,
	input  wire rx_word_t								host_arg_i,
	output logic										host_rd_o,
	output rx_word_t									host_dout_o,
	output logic										srq_o
);

	logic		word_valid;
	logic		word_ready;		// buffer not full
	rx_word_t	word_data;
	logic		block_done;
	rx_ctr_t	blk_count;
	logic		rd_en;
	rx_word_t	rd_data;
	logic		empty;
	rx_nsamps_t	nsamps_cfg;

	////////////////////////////////////////
	// producer
	////////////////////////////////////////

	rx_frame_sequencer u_sequencer (
		.cpu_clk		(cpu_clk),
		.reset_bufs_A	(reset_bufs_A),
		.frame_valid_i	(frame_valid_i),
		.frame_ready_o	(frame_ready_o),
		.frame_data_i	(frame_data_i),
		.word_valid_o	(word_valid),
		.word_ready_i	(word_ready),
		.word_data_o	(word_data),
		.ticks_sel_o	(ticks_sel_o),
		.ticks_i		(ticks_i),
		.nsamps_i		(nsamps_cfg),
		.block_done_o	(block_done),
		.blk_count_o	(blk_count)
	);

	// circular sample store
	rx_sample_ram u_ram (
		.cpu_clk		(cpu_clk),
		.reset_bufs_A	(reset_bufs_A),
		.wr_valid_i		(word_valid),
		.wr_ready_o		(word_ready),
		.wr_data_i		(word_data),
		.rd_en_i		(rd_en),
		.rd_data_o		(rd_data),
		.empty_o		(empty)
	);

	////////////////////////////////////////
	// consumer
	////////////////////////////////////////

	rx_host_reader u_reader (
		.cpu_clk			(cpu_clk),
		.reset_bufs_A		(reset_bufs_A),
		.host_cmd_valid_i	(host_cmd_valid_i),
		.host_cmd_ready_o	(host_cmd_ready_o),
		.host_cmd_i			(host_cmd_i),
		.host_arg_i			(host_arg_i),
		.buf_empty_i		(empty),
		.buf_rd_en_o		(rd_en),
		.buf_rd_data_i		(rd_data),
		.block_done_i		(block_done),
		.blk_count_i		(blk_count),
		.host_rd_o			(host_rd_o),
		.host_dout_o		(host_dout_o),
		.srq_o				(srq_o),
		.nsamps_o			(nsamps_cfg)
	);

endmodule

`default_nettype wire

// File: verilog/rx_frame_sequencer.sv
// frame sequencer module: frame latch, channel word interleave, tick and counter words, block count

`default_nettype none

`include "rx_buf_config.svh"

module rx_frame_sequencer
	import rx_buf_pkg::*;
(
	input  wire											cpu_clk,
	input  wire											reset_bufs_A,
	// frame input
	input  wire											frame_valid_i,
	output logic										frame_ready_o,
	input  wire rx_word_t [`RX_CHANS*`RX_WORDS_PER_CHAN-1:0]	frame_data_i,
	// word stream to the buffer
	output logic										word_valid_o,
	input  wire											word_ready_i,
	output rx_word_t									word_data_o,
	// tick source
	output logic [1:0]									ticks_sel_o,
	input  wire rx_word_t								ticks_i,
	// block control
	input  wire rx_nsamps_t								nsamps_i,
	output logic										block_done_o,
	output rx_ctr_t										blk_count_o
);

	localparam int FRAME_WORDS = `RX_CHANS * `RX_WORDS_PER_CHAN;
	localparam int WSEL_W = $clog2(FRAME_WORDS);

	seq_state_t					state;
	rx_word_t [FRAME_WORDS-1:0]	frame_q;		// latched frame
	rx_chan_t					chan;			// channel being moved
	logic [1:0]					move;			// I, Q, iq3 step or tick select
	rx_nsamps_t					frame_cnt;		// frames done in this block
	rx_nsamps_t					nsamps_q;		// block length, latched at block start
	logic [WSEL_W-1:0]			wsel;
	logic						frame_take;
	logic						last_move;
	logic						last_tick;
	logic						last_chan;
	logic						last_frame;

	////////////////////////////////////////
	// handshakes and step conditions
	////////////////////////////////////////

	assign frame_ready_o = (state == SEQ_IDLE);		// one frame at a time
	assign frame_take = frame_valid_i && frame_ready_o;
	assign word_valid_o = (state != SEQ_IDLE);

	assign last_move = (move == 2'(`RX_WORDS_PER_CHAN - 1));
	assign last_tick = (move == 2'd2);		// three tick words per block
	assign last_chan = (chan == rx_chan_t'(`RX_CHANS - 1));
	assign last_frame = (frame_cnt == rx_nsamps_t'(nsamps_q - 1'b1));

	// word slot inside the frame, channel major
	assign wsel = WSEL_W'(chan) * WSEL_W'(`RX_WORDS_PER_CHAN) + WSEL_W'(move);

	assign ticks_sel_o = (state == SEQ_TICKS) ? move : 2'd0;

	// source of the outgoing word
	always_comb
	begin
		case (state)
			SEQ_TICKS: word_data_o = ticks_i;
			SEQ_CTR:   word_data_o = blk_count_o;		// count before this block
			default:   word_data_o = frame_q[wsel];
		endcase
	end

	// frame payload
	always_ff @(posedge cpu_clk)
	begin
		if (frame_take)
			frame_q <= frame_data_i;
	end

	////////////////////////////////////////
	// state machine
	////////////////////////////////////////

	always_ff @(posedge cpu_clk)
	begin
		if (reset_bufs_A)
		begin
			state <= SEQ_IDLE;
			chan <= '0;
			move <= '0;
			frame_cnt <= '0;
			nsamps_q <= rx_nsamps_t'(`RX_DEF_NSAMPS);
			blk_count_o <= '0;
			block_done_o <= 1'b0;
		end
		else
		begin
			block_done_o <= 1'b0;		// single cycle pulse
			case (state)
				SEQ_IDLE:
				begin
					if (frame_take)
					begin
						chan <= '0;
						move <= '0;
						state <= SEQ_CHAN;
						if (frame_cnt == '0)
							nsamps_q <= nsamps_i;		// new block length applies here
					end
				end
				SEQ_CHAN:
				begin
					if (word_ready_i)		// else hold the word
					begin
						if (!last_move)
							move <= move + 2'd1;
						else
						begin
							move <= '0;
							if (!last_chan)
								chan <= chan + 1'b1;
							else if (last_frame)
								state <= SEQ_TICKS;		// block end, append ticks
							else
							begin
								frame_cnt <= frame_cnt + 1'b1;
								state <= SEQ_IDLE;
							end
						end
					end
				end
				SEQ_TICKS:
				begin
					if (word_ready_i)
					begin
						if (last_tick)
						begin
							move <= '0;
							state <= SEQ_CTR;
						end
						else
							move <= move + 2'd1;
					end
				end
				SEQ_CTR:
				begin
					if (word_ready_i)
					begin
						blk_count_o <= blk_count_o + 1'b1;
						block_done_o <= 1'b1;
						frame_cnt <= '0;
						state <= SEQ_IDLE;
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/rx_host_reader.sv
// host command handler: sample and counter reads, sticky service request, nsamps register

`default_nettype none

`include "rx_buf_config.svh"

module rx_host_reader
	import rx_buf_pkg::*;
(
	input  wire				cpu_clk,
	input  wire				reset_bufs_A,
	// host command port
	input  wire				host_cmd_valid_i,
	output logic			host_cmd_ready_o,
	input  wire host_cmd_t	host_cmd_i,
	input  wire rx_word_t	host_arg_i,
	// buffer read port
	input  wire				buf_empty_i,
	output logic			buf_rd_en_o,
	input  wire rx_word_t	buf_rd_data_i,
	// block status from the sequencer
	input  wire				block_done_i,
	input  wire rx_ctr_t	blk_count_i,
	// host response
	output logic			host_rd_o,
	output rx_word_t		host_dout_o,
	output logic			srq_o,
	output rx_nsamps_t		nsamps_o
);

	logic		accept;
	logic		is_samp;
	logic		is_ctr;
	logic		is_srq;
	logic		sel_ram;		// response comes from the buffer
	rx_word_t	resp_q;			// counter or srq response

	// stall only a sample read with nothing stored
	assign host_cmd_ready_o = !((host_cmd_i == CMD_GET_SAMP) && buf_empty_i);
	assign accept = host_cmd_valid_i && host_cmd_ready_o;

	assign is_samp = accept && (host_cmd_i == CMD_GET_SAMP);
	assign is_ctr = accept && (host_cmd_i == CMD_GET_BUF_CTR);
	assign is_srq = accept && (host_cmd_i == CMD_GET_SRQ);

	assign buf_rd_en_o = is_samp;		// ram data lands next cycle
	assign host_dout_o = sel_ram ? buf_rd_data_i : resp_q;

	// response payload
	always_ff @(posedge cpu_clk)
	begin
		if (is_ctr)
			resp_q <= blk_count_i;
		else if (is_srq)
			resp_q <= {15'd0, srq_o};		// flag before clearing
	end

	////////////////////////////////////////
	// strobe, srq flag, nsamps
	////////////////////////////////////////

	always_ff @(posedge cpu_clk)
	begin
		if (reset_bufs_A)
		begin
			host_rd_o <= 1'b0;
			sel_ram <= 1'b0;
			srq_o <= 1'b0;
			nsamps_o <= rx_nsamps_t'(`RX_DEF_NSAMPS);
		end
		else
		begin
			host_rd_o <= is_samp || is_ctr || is_srq;
			sel_ram <= is_samp;

			// a completing block wins over the clear
			if (block_done_i)
				srq_o <= 1'b1;
			else if (is_srq)
				srq_o <= 1'b0;

			if (accept && (host_cmd_i == CMD_SET_NSAMPS))
			begin
				if (host_arg_i > rx_word_t'((1 << `RX_NSAMPS_W) - 1))
					nsamps_o <= '1;		// clamp high
				else if (host_arg_i == '0)
					nsamps_o <= rx_nsamps_t'(1);		// at least one frame per block
				else
					nsamps_o <= host_arg_i[`RX_NSAMPS_W-1:0];
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/rx_sample_ram.sv
// circular sample memory with wrapping pointers, fill count, full and empty flags, registered read

`default_nettype none

`include "rx_buf_config.svh"

module rx_sample_ram
	import rx_buf_pkg::*;
(
	input  wire				cpu_clk,
	input  wire				reset_bufs_A,
	// write side from the sequencer
	input  wire				wr_valid_i,
	output logic			wr_ready_o,		// not full
	input  wire rx_word_t	wr_data_i,
	// read side from the host reader
	input  wire				rd_en_i,
	output rx_word_t		rd_data_o,		// valid the cycle after rd_en_i
	output logic			empty_o
);

	localparam int DEPTH = 1 << `RX_BUF_AW;

	rx_word_t				mem [DEPTH];
	rx_addr_t				wr_ptr;
	rx_addr_t				rd_ptr;
	logic [`RX_BUF_AW:0]	fill;		// one bit wider than the address
	logic					full;
	logic					do_wr;
	logic					do_rd;

	// fill reaches DEPTH exactly when the top bit sets
	assign full = fill[`RX_BUF_AW];
	assign empty_o = (fill == '0);
	assign wr_ready_o = !full;

	assign do_wr = wr_valid_i && !full;
	assign do_rd = rd_en_i && !empty_o;		// reads on empty are dropped

	////////////////////////////////////////
	// storage and read register
	////////////////////////////////////////

	always_ff @(posedge cpu_clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_data_i;
		if (do_rd)
			rd_data_o <= mem[rd_ptr];		// old data on a same slot collision never happens, not empty
	end

	////////////////////////////////////////
	// pointers and fill count
	////////////////////////////////////////

	always_ff @(posedge cpu_clk)
	begin
		if (reset_bufs_A)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;		// wraps at DEPTH
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;		// both or neither
			endcase
		end
	end

endmodule

`default_nettype wire
